/* hdl/dcache_settings.svh */
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// byte address and data word
`define DC_ADDR_W   32
`define DC_DATA_W   32

// 16-byte lines, 64 sets
`define DC_OFFSET_W 4
`define DC_INDEX_W  6
`define DC_TAG_W    (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W)

`define DC_WORDS    4

`endif

/* hdl/dcache_pkg.sv */
package dcache_pkg;
    `include "dcache_settings.svh"

    typedef enum logic [1:0] {
        MS_IDLE,
        MS_WRITEBACK,
        MS_REFILL,
        MS_RESPOND
    } miss_state_e;

    typedef struct packed {
        logic [`DC_ADDR_W-1:0]   addr;
        logic                    write;
        logic [`DC_DATA_W/8-1:0] strb;
        logic [`DC_DATA_W-1:0]   wdata;
    } cpu_req_t;

    typedef logic [`DC_INDEX_W-1:0] dc_index_t;
    typedef logic [`DC_TAG_W-1:0]   dc_tag_t;
    typedef logic [1:0]             dc_word_sel_t;

    function automatic dc_tag_t addr_tag(logic [`DC_ADDR_W-1:0] addr);
        return addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    endfunction

    function automatic dc_index_t addr_index(logic [`DC_ADDR_W-1:0] addr);
        return addr[`DC_OFFSET_W +: `DC_INDEX_W];
    endfunction

    // word in line, byte offset dropped
    function automatic dc_word_sel_t addr_word(logic [`DC_ADDR_W-1:0] addr);
        return addr[`DC_OFFSET_W-1:2];
    endfunction

    function automatic logic [`DC_ADDR_W-1:0] line_base(dc_tag_t tag, dc_index_t index);
        return {tag, index, {`DC_OFFSET_W{1'b0}}};
    endfunction
endpackage

/* hdl/axi_pkg.sv */
package axi_pkg;
    // beats minus one, as on the AXI len field
    typedef logic [7:0] burst_len_t;

    // log2 of bytes per beat
    typedef logic [2:0] burst_size_t;

    typedef enum logic {
        MEM_READ_LINE,
        MEM_WRITE_LINE
    } mem_op_e;
endpackage

/* hdl/dcache_if.sv */
`timescale 1ns/100ps
`include "dcache_settings.svh"

interface dcache_miss_if import dcache_pkg::*; ();
    logic                  miss_valid;
    logic                  miss_ready;
    cpu_req_t              miss_req;
    logic                  victim_way;
    logic                  victim_dirty;
    dc_tag_t               victim_tag;
    logic                  fill_done;
    logic [`DC_DATA_W-1:0] fill_rdata;

    modport master (
        output miss_valid, miss_req, victim_way, victim_dirty, victim_tag,
        input  miss_ready, fill_done, fill_rdata
    );

    modport slave (
        input  miss_valid, miss_req, victim_way, victim_dirty, victim_tag,
        output miss_ready, fill_done, fill_rdata
    );
endinterface

interface dcache_ram_if import dcache_pkg::*; ();
    // lookup side: read and hit write at the registered read address
    logic                       rd_en;
    dc_index_t                  rd_index;
    dc_word_sel_t               rd_word;
    logic                       hit_we;
    logic                       hit_way;
    logic [`DC_DATA_W/8-1:0]    hit_strb;
    logic [`DC_DATA_W-1:0]      hit_wdata;
    logic                       touch;

    // refill side
    logic                       fill_we;
    logic                       fill_way;
    dc_index_t                  fill_index;
    dc_word_sel_t               fill_word;
    logic [`DC_DATA_W-1:0]      fill_data;
    dc_tag_t                    fill_tag;
    logic                       tag_we;
    logic                       set_dirty;
    logic                       wb_rd_en;
    dc_word_sel_t               wb_word;

    // storage returns
    dc_tag_t [1:0]              rd_tag;
    logic [1:0][`DC_DATA_W-1:0] rd_data;
    logic [1:0]                 rd_valid;
    logic [1:0]                 rd_dirty;
    logic                       rd_lru;
    logic [`DC_DATA_W-1:0]      wb_rdata;

    modport lookup (
        output rd_en, rd_index, rd_word, hit_we, hit_way, hit_strb, hit_wdata, touch,
        input  rd_tag, rd_data, rd_valid, rd_dirty, rd_lru
    );

    modport refill (
        output fill_we, fill_way, fill_index, fill_word, fill_data, fill_tag,
        output tag_we, set_dirty, wb_rd_en, wb_word,
        input  wb_rdata
    );

    modport store (
        input  rd_en, rd_index, rd_word, hit_we, hit_way, hit_strb, hit_wdata, touch,
        input  fill_we, fill_way, fill_index, fill_word, fill_data, fill_tag,
        input  tag_we, set_dirty, wb_rd_en, wb_word,
        output rd_tag, rd_data, rd_valid, rd_dirty, rd_lru, wb_rdata
    );
endinterface

/* hdl/dcache_lookup.sv */
`timescale 1ns/100ps
`include "dcache_settings.svh"

module dcache_lookup import dcache_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  logic                    req_write,
    input  logic [`DC_ADDR_W-1:0]   req_addr,
    input  logic [`DC_DATA_W-1:0]   req_wdata,
    input  logic [`DC_DATA_W/8-1:0] req_strb,
    output logic                    req_ready,
    output logic                    resp_valid,
    output logic [`DC_DATA_W-1:0]   resp_rdata,
    input  logic                    resp_ready,
    dcache_ram_if.lookup            ram,
    dcache_miss_if.master           miss
);
    cpu_req_t              req_q;
    logic                  pend;
    logic                  init_done;
    logic                  miss_open;
    logic                  fill_resp;
    logic [`DC_DATA_W-1:0] fill_word_q;
    logic [1:0]            way_hit;
    logic                  hit;
    logic                  victim;
    logic                  accept;
    logic                  hit_fire;

    // compare stage, ram outputs belong to req_q
    assign way_hit[0] = ram.rd_valid[0] && (ram.rd_tag[0] == addr_tag(req_q.addr));
    assign way_hit[1] = ram.rd_valid[1] && (ram.rd_tag[1] == addr_tag(req_q.addr));
    assign hit        = |way_hit;
    assign victim     = hit ? way_hit[1] : ram.rd_lru;

    assign resp_valid = fill_resp || (pend && hit);
    assign resp_rdata = fill_resp ? fill_word_q : ram.rd_data[victim];
    assign hit_fire   = pend && hit && resp_ready;

    // a new request only when the compare stage empties this cycle
    assign req_ready = init_done && !miss_open && (!pend || hit_fire);
    assign accept    = req_valid && req_ready;

    assign ram.rd_en     = accept;
    assign ram.rd_index  = addr_index(req_addr);
    assign ram.rd_word   = addr_word(req_addr);
    assign ram.hit_we    = hit_fire && req_q.write;
    assign ram.touch     = hit_fire && !req_q.write;
    assign ram.hit_way   = victim;
    assign ram.hit_strb  = req_q.strb;
    assign ram.hit_wdata = req_q.wdata;

    assign miss.miss_req = req_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            init_done       <= 1'b0;
            pend            <= 1'b0;
            miss_open       <= 1'b0;
            fill_resp       <= 1'b0;
            miss.miss_valid <= 1'b0;
        end else begin
            init_done <= 1'b1;
            pend      <= accept || (pend && hit && !resp_ready);

            if (pend && !hit) begin
                miss_open       <= 1'b1;
                miss.miss_valid <= 1'b1;
            end else if (fill_resp && resp_ready) begin
                miss_open <= 1'b0;
            end

            if (miss.miss_valid && miss.miss_ready) begin
                miss.miss_valid <= 1'b0;
            end

            if (miss.fill_done) begin
                fill_resp <= 1'b1;
            end else if (resp_ready) begin
                fill_resp <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= '{addr: req_addr, write: req_write, strb: req_strb, wdata: req_wdata};
        end
        // victim fields held until the refill is done
        if (pend && !hit) begin
            miss.victim_way   <= victim;
            miss.victim_dirty <= ram.rd_dirty[victim];
            miss.victim_tag   <= ram.rd_tag[victim];
        end
        if (miss.fill_done) begin
            fill_word_q <= miss.fill_rdata;
        end
    end
endmodule

/* hdl/dcache_ways.sv */
`timescale 1ns/100ps
`include "dcache_settings.svh"

module dcache_ways import dcache_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    dcache_ram_if.store  ram
);
    localparam int SETS   = 1 << `DC_INDEX_W;
    localparam int WA_W   = `DC_INDEX_W + $bits(dc_word_sel_t);
    localparam int BYTES  = `DC_DATA_W / 8;

    dc_tag_t               tag_mem  [2][SETS];
    logic [`DC_DATA_W-1:0] data_mem [2][SETS * `DC_WORDS];
    logic [1:0]            valid    [SETS];
    logic [1:0]            dirty    [SETS];
    // way to replace next
    logic                  lru      [SETS];

    dc_index_t             rd_index_q;
    dc_word_sel_t          rd_word_q;
    logic [WA_W-1:0]       wb_addr_q;
    logic                  wb_way_q;

    logic                  we_way;
    logic [WA_W-1:0]       we_addr;
    logic [BYTES-1:0]      we_strb;
    logic [`DC_DATA_W-1:0] we_data;

    // one data write port, fill and hit writes never overlap
    always_comb begin
        if (ram.fill_we) begin
            we_way  = ram.fill_way;
            we_addr = {ram.fill_index, ram.fill_word};
            we_strb = '1;
            we_data = ram.fill_data;
        end else begin
            we_way  = ram.hit_way;
            we_addr = {rd_index_q, rd_word_q};
            we_strb = ram.hit_we ? ram.hit_strb : '0;
            we_data = ram.hit_wdata;
        end
    end

    always_ff @(posedge clk) begin
        for (int b = 0; b < BYTES; b++) begin
            if (we_strb[b]) begin
                data_mem[we_way][we_addr][8*b +: 8] <= we_data[8*b +: 8];
            end
        end
        if (ram.tag_we) begin
            tag_mem[ram.fill_way][ram.fill_index] <= ram.fill_tag;
        end
        if (ram.rd_en) begin
            rd_index_q <= ram.rd_index;
            rd_word_q  <= ram.rd_word;
        end
        if (ram.wb_rd_en) begin
            wb_addr_q <= {ram.fill_index, ram.wb_word};
            wb_way_q  <= ram.fill_way;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '{default: '0};
            dirty <= '{default: '0};
            lru   <= '{default: 1'b0};
        end else begin
            if (ram.tag_we) begin
                valid[ram.fill_index][ram.fill_way] <= 1'b1;
                dirty[ram.fill_index][ram.fill_way] <= 1'b0;
                lru[ram.fill_index]                 <= !ram.fill_way;
            end
            if (ram.set_dirty) begin
                dirty[ram.fill_index][ram.fill_way] <= 1'b1;
            end
            if (ram.hit_we) begin
                dirty[rd_index_q][ram.hit_way] <= 1'b1;
            end
            if (ram.hit_we || ram.touch) begin
                lru[rd_index_q] <= !ram.hit_way;
            end
        end
    end

    for (genvar w = 0; w < 2; w++) begin : g_way
        assign ram.rd_tag[w]  = tag_mem[w][rd_index_q];
        assign ram.rd_data[w] = data_mem[w][{rd_index_q, rd_word_q}];
    end

    assign ram.rd_valid = valid[rd_index_q];
    assign ram.rd_dirty = dirty[rd_index_q];
    assign ram.rd_lru   = lru[rd_index_q];
    assign ram.wb_rdata = data_mem[wb_way_q][wb_addr_q];
endmodule

/* hdl/dcache_refill.sv */
`timescale 1ns/100ps
`include "dcache_settings.svh"

module dcache_refill import dcache_pkg::*; import axi_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    dcache_miss_if.slave            miss,
    dcache_ram_if.refill            ram,
    output logic [`DC_ADDR_W-1:0]   araddr,
    output burst_len_t              arlen,
    output burst_size_t             arsize,
    output logic                    arvalid,
    input  logic                    arready,
    input  logic [`DC_DATA_W-1:0]   rdata,
    input  logic                    rlast,
    input  logic                    rvalid,
    output logic                    rready,
    output logic [`DC_ADDR_W-1:0]   awaddr,
    output burst_len_t              awlen,
    output burst_size_t             awsize,
    output logic                    awvalid,
    input  logic                    awready,
    output logic [`DC_DATA_W-1:0]   wdata,
    output logic [`DC_DATA_W/8-1:0] wstrb,
    output logic                    wlast,
    output logic                    wvalid,
    input  logic                    wready,
    input  logic                    bvalid,
    output logic                    bready
);
    miss_state_e           state;
    mem_op_e               first_op;
    dc_word_sel_t          beat;
    dc_word_sel_t          req_word;
    logic                  wb_pending;
    logic                  miss_fire;
    logic                  r_fire;
    logic                  w_fire;
    logic [`DC_DATA_W-1:0] merged;
    logic [`DC_DATA_W-1:0] word_q;

    assign miss_fire = miss.miss_valid && miss.miss_ready;
    assign r_fire    = rvalid && rready;
    assign w_fire    = wvalid && wready;
    assign first_op  = miss.victim_dirty ? MEM_WRITE_LINE : MEM_READ_LINE;
    assign req_word  = addr_word(miss.miss_req.addr);

    // whole-line incrementing bursts of full words
    assign arlen  = burst_len_t'(`DC_WORDS - 1);
    assign awlen  = burst_len_t'(`DC_WORDS - 1);
    assign arsize = burst_size_t'($clog2(`DC_DATA_W / 8));
    assign awsize = burst_size_t'($clog2(`DC_DATA_W / 8));
    assign wstrb  = '1;
    assign bready = 1'b1;

    assign miss.miss_ready = (state == MS_IDLE);
    assign miss.fill_done  = (state == MS_RESPOND);
    assign miss.fill_rdata = word_q;

    // pending store bytes over the refilled word
    always_comb begin
        merged = rdata;
        if (miss.miss_req.write && beat == req_word) begin
            for (int b = 0; b < `DC_DATA_W / 8; b++) begin
                if (miss.miss_req.strb[b]) begin
                    merged[8*b +: 8] = miss.miss_req.wdata[8*b +: 8];
                end
            end
        end
    end

    assign ram.fill_we    = r_fire;
    assign ram.fill_way   = miss.victim_way;
    assign ram.fill_index = addr_index(miss.miss_req.addr);
    assign ram.fill_word  = beat;
    assign ram.fill_data  = merged;
    assign ram.fill_tag   = addr_tag(miss.miss_req.addr);
    assign ram.tag_we     = r_fire && rlast;
    assign ram.set_dirty  = miss.fill_done && miss.miss_req.write;

    // victim words are fetched one at a time, next one after each W beat
    assign ram.wb_rd_en = (miss_fire && first_op == MEM_WRITE_LINE)
                          || (state == MS_WRITEBACK && w_fire && !wlast);
    assign ram.wb_word  = (state == MS_IDLE) ? '0 : beat + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= MS_IDLE;
            beat       <= '0;
            wb_pending <= 1'b0;
            arvalid    <= 1'b0;
            rready     <= 1'b0;
            awvalid    <= 1'b0;
            wvalid     <= 1'b0;
            wlast      <= 1'b0;
        end else begin
            wb_pending <= ram.wb_rd_en;
            case (state)
                MS_IDLE: begin
                    if (miss_fire) begin
                        beat <= '0;
                        if (first_op == MEM_WRITE_LINE) begin
                            awvalid <= 1'b1;
                            state   <= MS_WRITEBACK;
                        end else begin
                            arvalid <= 1'b1;
                            state   <= MS_REFILL;
                        end
                    end
                end
                MS_WRITEBACK: begin
                    if (awvalid && awready) begin
                        awvalid <= 1'b0;
                    end
                    if (wb_pending) begin
                        wvalid <= 1'b1;
                        wlast  <= (beat == dc_word_sel_t'(`DC_WORDS - 1));
                    end else if (w_fire) begin
                        wvalid <= 1'b0;
                        wlast  <= 1'b0;
                        beat   <= beat + 1'b1;
                    end
                    if (bvalid) begin
                        beat    <= '0;
                        arvalid <= 1'b1;
                        state   <= MS_REFILL;
                    end
                end
                MS_REFILL: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                    end
                    if (r_fire) begin
                        beat <= beat + 1'b1;
                        if (rlast) begin
                            rready <= 1'b0;
                            state  <= MS_RESPOND;
                        end
                    end
                end
                MS_RESPOND: state <= MS_IDLE;
                default:    state <= MS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (miss_fire) begin
            awaddr <= line_base(miss.victim_tag, addr_index(miss.miss_req.addr));
            araddr <= line_base(addr_tag(miss.miss_req.addr), addr_index(miss.miss_req.addr));
        end
        if (wb_pending) begin
            wdata <= ram.wb_rdata;
        end
        // requested word as it came from memory
        if (r_fire && beat == req_word) begin
            word_q <= rdata;
        end
    end
endmodule

/* hdl/dcache_top.sv */
`timescale 1ns/100ps
`include "dcache_settings.svh"

module dcache_top import axi_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  logic [`DC_ADDR_W-1:0]   req_addr,
    input  logic                    req_write,
    input  logic [`DC_DATA_W/8-1:0] req_strb,
    input  logic [`DC_DATA_W-1:0]   req_wdata,
    output logic                    req_ready,
    output logic                    resp_valid,
    output logic [`DC_DATA_W-1:0]   resp_rdata,
    input  logic                    resp_ready,
    output logic [`DC_ADDR_W-1:0]   araddr,
    output burst_len_t              arlen,
    output burst_size_t             arsize,
    output logic                    arvalid,
    input  logic                    arready,
    input  logic [`DC_DATA_W-1:0]   rdata,
    input  logic                    rlast,
    input  logic                    rvalid,
    output logic                    rready,
    output logic [`DC_ADDR_W-1:0]   awaddr,
    output burst_len_t              awlen,
    output burst_size_t             awsize,
    output logic                    awvalid,
    input  logic                    awready,
    output logic [`DC_DATA_W-1:0]   wdata,
    output logic [`DC_DATA_W/8-1:0] wstrb,
    output logic                    wlast,
    output logic                    wvalid,
    input  logic                    wready,
    input  logic                    bvalid,
    output logic                    bready
);
    dcache_miss_if miss_if ();
    dcache_ram_if  ram_if ();

    dcache_lookup u_lookup (
        .ram  (ram_if.lookup),
        .miss (miss_if.master),
        .*
    );

    dcache_ways u_ways (
        .clk (clk),
        .rst (rst),
        .ram (ram_if.store)
    );

    // write-back and refill bursts
    dcache_refill u_refill (
        .miss (miss_if.slave),
        .ram  (ram_if.refill),
        .*
    );
endmodule

/* testbench/tb_mem_model.sv */
`timescale 1ns/100ps

module tb_mem_model import axi_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] araddr,
    input  burst_len_t  arlen,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rlast,
    output logic        rvalid,
    input  logic        rready,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic        wlast,
    input  logic        wvalid,
    output logic        wready,
    output logic        bvalid,
    output int          read_bursts,
    output int          write_bursts,
    output logic [31:0] wb_addr,
    output int          wb_beats
);
    logic [31:0] mem [logic [31:0]];
    int          seed = 32'h0ba0296c;
    logic [31:0] rnd;
    logic        rd_active;
    logic        wr_active;
    logic [31:0] rd_addr;
    logic [31:0] wr_addr;
    burst_len_t  rd_left;
    int          wr_count;

    // unwritten words follow the address pattern
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return a ^ 32'h5a5a0000;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            awready <= 1'b0;
            rvalid <= 1'b0;
            rlast <= 1'b0;
            wready <= 1'b0;
            bvalid <= 1'b0;
            rd_active <= 1'b0;
            wr_active <= 1'b0;
            read_bursts <= 0;
            write_bursts <= 0;
            wb_beats <= 0;
            wb_addr <= '0;
        end else begin
            rnd = $random(seed);
            arready <= rnd[0] && !rd_active;
            awready <= rnd[1] && !wr_active;
            bvalid <= 1'b0;

            if (!rd_active && arvalid && arready) begin
                rd_active <= 1'b1;
                arready <= 1'b0;
                rd_addr <= araddr;
                rd_left <= arlen;
                rvalid <= 1'b1;
                rdata <= mem_word(araddr);
                rlast <= (arlen == 8'd0);
                read_bursts <= read_bursts + 1;
            end else if (rd_active && rvalid && rready) begin
                if (rlast) begin
                    rvalid <= 1'b0;
                    rlast <= 1'b0;
                    rd_active <= 1'b0;
                end else begin
                    rd_addr <= rd_addr + 32'd4;
                    rdata <= mem_word(rd_addr + 32'd4);
                    rlast <= (rd_left == 8'd1);
                    rd_left <= rd_left - 8'd1;
                end
            end

            // W beats only after the address is taken
            if (!wr_active && awvalid && awready) begin
                wr_active <= 1'b1;
                awready <= 1'b0;
                wr_addr <= awaddr;
                wb_addr <= awaddr;
                wr_count <= 0;
                wready <= 1'b1;
            end else if (wr_active && wvalid && wready) begin
                mem[wr_addr] = wdata;
                wr_addr <= wr_addr + 32'd4;
                wr_count <= wr_count + 1;
                if (wlast) begin
                    wready <= 1'b0;
                    wr_active <= 1'b0;
                    bvalid <= 1'b1;
                    write_bursts <= write_bursts + 1;
                    wb_beats <= wr_count + 1;
                end
            end
        end
    end
endmodule

/* testbench/dcache_sva.sv */
`timescale 1ns/100ps

module dcache_sva (
    input logic        clk,
    input logic        rst,
    input logic        resp_valid,
    input logic        resp_ready,
    input logic [31:0] resp_rdata,
    input logic        arvalid,
    input logic        arready,
    input logic        awvalid,
    input logic        awready,
    input logic        wvalid,
    input logic        wready,
    input logic        hit_we,
    input logic        fill_we
);
    // response held under back-pressure
    assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata))
        else $error("response changed while stalled");

    assert property (@(posedge clk) disable iff (rst) !(hit_we && fill_we))
        else $error("hit write and fill write in the same cycle");

    assert property (@(posedge clk) disable iff (rst) arvalid && !arready |=> arvalid)
        else $error("arvalid dropped without arready");

    assert property (@(posedge clk) disable iff (rst) awvalid && !awready |=> awvalid)
        else $error("awvalid dropped without awready");

    assert property (@(posedge clk) disable iff (rst) wvalid && !wready |=> wvalid)
        else $error("wvalid dropped without wready");
endmodule

bind dcache_top dcache_sva u_sva (
    .clk        (clk),
    .rst        (rst),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .resp_rdata (resp_rdata),
    .arvalid    (arvalid),
    .arready    (arready),
    .awvalid    (awvalid),
    .awready    (awready),
    .wvalid     (wvalid),
    .wready     (wready),
    .hit_we     (ram_if.hit_we),
    .fill_we    (ram_if.fill_we)
);

/* testbench/tb_dcache.sv */
`timescale 1ns/100ps
`include "dcache_settings.svh"

module tb_dcache import axi_pkg::*; ();
    logic        clk;
    logic        rst;
    logic        req_valid;
    logic [31:0] req_addr;
    logic        req_write;
    logic [3:0]  req_strb;
    logic [31:0] req_wdata;
    logic        req_ready;
    logic        resp_valid;
    logic [31:0] resp_rdata;
    logic        resp_ready;
    logic [31:0] araddr, awaddr, rdata, wdata, wb_addr;
    burst_len_t  arlen, awlen;
    burst_size_t arsize, awsize;
    logic        arvalid, arready, rlast, rvalid, rready;
    logic        awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic [3:0]  wstrb;
    int          read_bursts, write_bursts, wb_beats;

    logic [7:0]  op_q[$];
    logic [31:0] addr_q[$], strb_q[$], wdata_q[$], exp_q[$];
    int          rd_q[$], wr_q[$];
    int          seed = 32'h0ba0296c;
    logic        loaded = 1'b0;

    dcache_top u_dut (.*);

    tb_mem_model u_mem (.*);

    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_golden();
        int          fd;
        int          n;
        string       line;
        logic [7:0]  op_c;
        logic [31:0] a, s, w, e;
        int          rc, wc;
        fd = $fopen("testbench/dcache_golden.txt", "r");
        if (fd == 0) begin
            $display("golden file could not be opened");
            $display("TESTBENCH FAILED");
            $fatal(1, "missing golden file");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%c %h %h %h %h %d %d", op_c, a, s, w, e, rc, wc);
                if (n == 7) begin
                    op_q.push_back(op_c);
                    addr_q.push_back(a);
                    strb_q.push_back(s);
                    wdata_q.push_back(w);
                    exp_q.push_back(e);
                    rd_q.push_back(rc);
                    wr_q.push_back(wc);
                end
            end
        end
        $fclose(fd);
    endtask

    // one request through to its response
    // B ops hold resp_ready low for a while
    task automatic run_op(input int i);
        string       name;
        int          lat;
        int          hold;
        int          prev_rd;
        int          prev_wr;
        logic [31:0] rnd;
        name = $sformatf("line %0d op %c addr %h", i, op_q[i], addr_q[i]);
        prev_rd = read_bursts;
        prev_wr = write_bursts;
        @(posedge clk);
        req_valid <= 1'b1;
        req_addr <= addr_q[i];
        req_write <= (op_q[i] == "W");
        req_strb <= strb_q[i][3:0];
        req_wdata <= wdata_q[i];
        resp_ready <= (op_q[i] != "B");
        @(negedge clk);
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        req_valid <= 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!resp_valid);
        if (op_q[i] != "W") begin
            check_value(name, exp_q[i], resp_rdata);
        end
        if (rd_q[i] == prev_rd) begin
            check_value({name, " hit latency"}, 32'd1, 32'(lat));
        end
        check_value({name, " read bursts"}, 32'(rd_q[i]), 32'(read_bursts));
        check_value({name, " write bursts"}, 32'(wr_q[i]), 32'(write_bursts));
        if (read_bursts != prev_rd) begin
            check_value({name, " arlen"}, `DC_WORDS - 1, 32'(arlen));
            check_value({name, " arsize"}, 32'd2, 32'(arsize));
        end
        if (write_bursts != prev_wr) begin
            check_value({name, " write beats"}, `DC_WORDS, 32'(wb_beats));
            // victim shares the set of the request
            check_value({name, " write base"}, addr_q[i] & 32'h0000_03f0,
                        wb_addr & 32'h0000_03ff);
            check_value({name, " awlen"}, `DC_WORDS - 1, 32'(awlen));
            check_value({name, " awsize"}, 32'd2, 32'(awsize));
            check_value({name, " wstrb"}, 32'h0000_000f, 32'(wstrb));
        end
        check_value({name, " bready"}, 32'd1, 32'(bready));
        if (op_q[i] == "B") begin
            rnd = $random(seed);
            hold = 1 + int'(rnd[2:0]);
            repeat (hold) begin
                check_value({name, " held valid"}, 32'd1, 32'(resp_valid));
                check_value({name, " held data"}, exp_q[i], resp_rdata);
                check_value({name, " req_ready"}, 32'd0, {31'd0, req_ready});
                @(negedge clk);
            end
            @(posedge clk);
            resp_ready <= 1'b1;
        end
    endtask

    initial begin
        int limit;
        wait (loaded);
        limit = 200 * op_q.size() + 20;
        repeat (limit) @(posedge clk);
        $display("watchdog timeout after %0d cycles, the cache stopped responding", limit);
        $display("TESTBENCH FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        req_valid = 1'b0;
        req_addr = '0;
        req_write = 1'b0;
        req_strb = '0;
        req_wdata = '0;
        resp_ready = 1'b1;
        load_golden();
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < op_q.size(); i++) begin
            run_op(i);
        end
        @(posedge clk);
        $display("TESTBENCH PASSED");
        $finish;
    end
endmodule

/* testbench/dcache_golden.txt */
# op (R read, W store, B read with stalled response) addr strb wdata (hex)
# expected rdata (hex, unused for W) then read and write burst totals (decimal)
R 00000010 f 00000000 5a5a0010 1 0
R 00000014 f 00000000 5a5a0014 1 0
W 00000018 3 aabbccdd 00000000 1 0
R 00000018 f 00000000 5a5accdd 1 0
R 00000410 f 00000000 5a5a0410 2 0
R 00000010 f 00000000 5a5a0010 2 0
R 00000810 f 00000000 5a5a0810 3 0
R 0000001c f 00000000 5a5a001c 3 0
R 00000414 f 00000000 5a5a0414 4 0
R 00000c10 f 00000000 5a5a0c10 5 1
R 00000018 f 00000000 5a5accdd 6 1
W 00002024 c 11223344 00000000 7 1
R 00002024 f 00000000 11222024 7 1
B 00002020 f 00000000 5a5a2020 7 1
B 00003020 f 00000000 5a5a3020 8 1
R 00003020 f 00000000 5a5a3020 8 1
W 00000c14 f deadbeef 00000000 8 1
R 00001010 f 00000000 5a5a1010 9 1
R 00001410 f 00000000 5a5a1410 10 2
R 00000c14 f 00000000 deadbeef 11 2
B 00000c18 f 00000000 5a5a0c18 11 2

/* list.f */
+incdir+hdl
hdl/dcache_pkg.sv
hdl/axi_pkg.sv
hdl/dcache_if.sv
hdl/dcache_lookup.sv
hdl/dcache_ways.sv
hdl/dcache_refill.sv
hdl/dcache_top.sv
testbench/tb_mem_model.sv
testbench/dcache_sva.sv
testbench/tb_dcache.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module tb_dcache -o tb_dcache_sim \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_dcache_sim > sim.log 2>&1
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"
